//--- tb.f
verilog/sb_pkg.sv
verilog/sb_txn_sequencer.sv
verilog/sb_symbol_fifo.sv
verilog/sb_symbol_timer.sv
verilog/sb_tx_top.sv
verif/sb_tx_clkgen.sv
verif/sb_tx_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := sb_tx_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/sb_tx_tb.sv
`timescale 1ns/1ps

module sb_tx_tb;

    localparam int         RAND_SEED     = 49878;
    localparam int         HOLD          = 10;        // Cycles per symbol on the line
    localparam int         START_TIMEOUT = 40;        // Request to first symbol
    localparam int         LEVEL_TIMEOUT = 20;        // Line level change
    localparam int         QUIET_WINDOW  = 40;        // Cycles watched for no traffic
    localparam logic [9:0] IDLE_LEVEL    = 10'h3FF;
    localparam logic [9:0] DISC_LEVEL    = 10'h000;

    logic                sb_clk;
    logic                rst;
    logic [23:0]         sb_read;
    sb_pkg::txn_sel_e    trans_sel;
    logic                disconnect_sbtx;
    logic                tdisconnect_tx_min;
    logic [9:0]          trans;
    sb_pkg::link_state_e trans_state;
    logic                crc_en;
    logic                sbtx_sel;
    logic                trans_sent;
    logic                disconnected;

    logic [9:0] exp_sym[$];                           // Expected frame, in line order
    logic       exp_crc[$];
    logic       exp_sel[$];

    sb_tx_clkgen u_clkgen (
        .sb_clk (sb_clk),
        .rst    (rst)
    );

    sb_tx_top #(
        .FIFO_DEPTH (4)
    ) uut (
        .sb_clk             (sb_clk),
        .rst                (rst),
        .sb_read            (sb_read),
        .trans_sel          (trans_sel),
        .disconnect_sbtx    (disconnect_sbtx),
        .tdisconnect_tx_min (tdisconnect_tx_min),
        .trans              (trans),
        .trans_state        (trans_state),
        .crc_en             (crc_en),
        .sbtx_sel           (sbtx_sel),
        .trans_sent         (trans_sent),
        .disconnected       (disconnected)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic step();
        @(posedge sb_clk);
        #1;                                           // Drive and sample point
    endtask

    // Start bit high, payload byte, stop bit low
    function automatic logic [9:0] frame(input logic [7:0] payload);
        return {1'b1, payload, 1'b0};
    endfunction

    task automatic expect_sym(input logic [9:0] sym, input logic crc, input logic sel);
        exp_sym.push_back(sym);
        exp_crc.push_back(crc);
        exp_sel.push_back(sel);
    endtask

    task automatic model_train();
        exp_sym.delete();
        exp_crc.delete();
        exp_sel.delete();
        expect_sym(frame(8'hFE), 1'b0, 1'b0);         // DLE
        expect_sym(frame(8'h80), 1'b0, 1'b0);         // LSE
        expect_sym(frame(8'h7F), 1'b0, 1'b0);         // CLSE, no CRC in training
    endtask

    task automatic model_read(input logic rsp, input logic [23:0] data);
        exp_sym.delete();
        exp_crc.delete();
        exp_sel.delete();
        expect_sym(frame(8'hFE), 1'b0, 1'b0);
        expect_sym(frame(rsp ? 8'h04 : 8'h05), 1'b1, 1'b0); // CRC coverage starts at STX
        expect_sym(frame(8'h4E), 1'b1, 1'b0);         // Address
        expect_sym(frame(8'h03), 1'b1, 1'b0);         // Length
        if (rsp) begin
            expect_sym(frame(data[7:0]), 1'b1, 1'b0); // Low byte first
            expect_sym(frame(data[15:8]), 1'b1, 1'b0);
            expect_sym(frame(data[23:16]), 1'b1, 1'b0);
        end
        expect_sym(10'h000, 1'b0, 1'b1);             // CRC slots
        expect_sym(10'h000, 1'b0, 1'b1);
        expect_sym(frame(8'hFE), 1'b0, 1'b0);
        expect_sym(frame(8'h40), 1'b0, 1'b0);         // ETX
    endtask

    // One-cycle request strobe while idle
    task automatic request(input logic [2:0] code, input logic [23:0] data);
        sb_read   = data;
        trans_sel = sb_pkg::txn_sel_e'(code);
        step();
        trans_sel = sb_pkg::TXN_NONE;
    endtask

    task automatic wait_level(input logic [9:0] level, input string what);
        int n;
        n = 0;
        while (trans !== level) begin
            if (n >= LEVEL_TIMEOUT) begin
                abort_run($sformatf("%s: trans did not reach 0x%0h within %0d cycles",
                                    what, level, LEVEL_TIMEOUT));
            end
            step();
            n++;
        end
    endtask

    task automatic watch_quiet(input logic [9:0] level, input string what);
        int n;
        for (n = 0; n < QUIET_WINDOW; n++) begin
            check_eq({what, " trans"}, trans, level);
            check_eq({what, " trans_sent"}, trans_sent, 1'b0);
            step();
        end
    endtask

    // Follows one frame symbol by symbol against the expected queues
    task automatic receive_frame(input string label);
        int n_wait;
        int i;
        int c;
        n_wait = 0;
        while (trans === IDLE_LEVEL) begin            // First symbol ends the idle line
            if (n_wait >= START_TIMEOUT) begin
                abort_run($sformatf("%s: no symbol appeared on trans within %0d cycles",
                                    label, START_TIMEOUT));
            end
            step();
            n_wait++;
        end
        check_eq({label, " trans_state"}, trans_state, sb_pkg::LINK_BUSY);
        for (i = 0; i < exp_sym.size(); i++) begin
            for (c = 0; c < HOLD; c++) begin          // Every hold cycle, middle included
                check_eq($sformatf("%s trans (symbol %0d, cycle %0d)", label, i, c),
                         trans, exp_sym[i]);
                check_eq($sformatf("%s crc_en (symbol %0d)", label, i), crc_en, exp_crc[i]);
                check_eq($sformatf("%s sbtx_sel (symbol %0d)", label, i),
                         sbtx_sel, exp_sel[i]);
                check_eq({label, " trans_sent"}, trans_sent, 1'b0);
                step();
            end
        end
        check_eq({label, " trans after frame"}, trans, IDLE_LEVEL); // Exactly ten cycles each
        check_eq({label, " trans_sent"}, trans_sent, 1'b1);
        step();
        check_eq({label, " trans_sent"}, trans_sent, 1'b0); // Single pulse
    endtask

    task automatic test_reset_release();
        int n;
        n = 0;
        step();
        check_eq("trans", trans, DISC_LEVEL);
        check_eq("disconnected", disconnected, 1'b1);
        while (!rst) begin
            if (n >= LEVEL_TIMEOUT) begin
                abort_run("reset was never released");
            end
            step();
            n++;
        end
        repeat (3) step();
        check_eq("trans", trans, DISC_LEVEL);         // Still held by disconnect_sbtx
        check_eq("disconnected", disconnected, 1'b1);
        check_eq("trans_state", trans_state, sb_pkg::LINK_DISC);
        check_eq("crc_en", crc_en, 1'b0);
        check_eq("sbtx_sel", sbtx_sel, 1'b0);
        check_eq("trans_sent", trans_sent, 1'b0);
        disconnect_sbtx = 1'b0;                       // Minimum time not yet met
        repeat (5) step();
        check_eq("trans", trans, DISC_LEVEL);
        tdisconnect_tx_min = 1'b1;
        wait_level(IDLE_LEVEL, "release");
        check_eq("trans_state", trans_state, sb_pkg::LINK_IDLE);
        check_eq("disconnected", disconnected, 1'b0);
    endtask

    task automatic test_train();
        model_train();
        request(3'd4, 24'h0);
        receive_frame("train");
    endtask

    task automatic test_read_cmd();
        model_read(1'b0, 24'h0);
        request(3'd2, 24'hA5A5A5);                    // Data ignored for a command
        receive_frame("read cmd");
    endtask

    task automatic test_read_rsp();
        logic [23:0] data;
        repeat (3) begin
            data = 24'($urandom());
            model_read(1'b1, data);
            request(3'd3, data);
            sb_read = ~data;                          // Must come from the latched copy
            receive_frame($sformatf("read rsp 0x%06h", data));
        end
    endtask

    task automatic test_illegal_codes();
        logic [2:0] codes[4];
        int k;
        codes = '{3'd1, 3'd5, 3'd6, 3'd7};
        for (k = 0; k < 4; k++) begin
            trans_sel = sb_pkg::txn_sel_e'(codes[k]); // Held for the whole window
            step();
            watch_quiet(IDLE_LEVEL, $sformatf("code %0d", codes[k]));
            trans_sel = sb_pkg::TXN_NONE;
        end
    endtask

    task automatic test_disconnect_request();
        disconnect_sbtx = 1'b1;
        trans_sel       = sb_pkg::TXN_TRAIN;          // Request meets disconnect
        step();
        wait_level(DISC_LEVEL, "disconnect");
        watch_quiet(DISC_LEVEL, "disconnected request");
        check_eq("disconnected", disconnected, 1'b1);
        check_eq("trans_state", trans_state, sb_pkg::LINK_DISC);
        trans_sel       = sb_pkg::TXN_NONE;
        step();
        disconnect_sbtx = 1'b0;
        wait_level(IDLE_LEVEL, "reconnect");
        model_read(1'b0, 24'h0);
        request(3'd2, 24'h0);
        receive_frame("read cmd after reconnect");
    endtask

    initial begin
        sb_read            = '0;
        trans_sel          = sb_pkg::TXN_NONE;
        disconnect_sbtx    = 1'b1;
        tdisconnect_tx_min = 1'b0;
        void'($urandom(RAND_SEED));
        test_reset_release();
        test_train();
        test_read_cmd();
        test_read_rsp();
        test_illegal_codes();
        test_disconnect_request();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verif/sb_tx_clkgen.sv
`timescale 1ns/1ps

module sb_tx_clkgen #(
    parameter int HALF_NS      = 2,                   // 4 ns period
    parameter int RESET_CYCLES = 2
) (
    output logic sb_clk,
    output logic rst
);

    initial begin
        sb_clk = 1'b0;
        forever #(HALF_NS) sb_clk = ~sb_clk;
    end

    initial begin
        rst = 1'b0;                                   // Active low from time zero
        repeat (RESET_CYCLES) @(posedge sb_clk);
        @(negedge sb_clk);                            // Release away from the sampling point
        rst = 1'b1;
    end

endmodule

//--- verilog/sb_tx_top.sv
`timescale 1ns/1ps

module sb_tx_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                sb_clk,
    input  logic                rst,
    input  logic [23:0]         sb_read,
    input  sb_pkg::txn_sel_e    trans_sel,
    input  logic                disconnect_sbtx,
    input  logic                tdisconnect_tx_min,
    output logic [9:0]          trans,
    output sb_pkg::link_state_e trans_state,
    output logic                crc_en,
    output logic                sbtx_sel,
    output logic                trans_sent,
    output logic                disconnected
);

    logic                push;
    logic                pop;
    logic                full;
    logic                empty;
    sb_pkg::sym_entry_t  wr_entry;                    // Sequencer to FIFO
    sb_pkg::sym_entry_t  rd_entry;                    // FIFO head to timer
    sb_pkg::link_state_e link_state;

    sb_txn_sequencer u_seq (
        .sb_clk             (sb_clk),
        .rst                (rst),
        .sb_read            (sb_read),
        .trans_sel          (trans_sel),
        .disconnect_sbtx    (disconnect_sbtx),
        .tdisconnect_tx_min (tdisconnect_tx_min),
        .full               (full),
        .push               (push),
        .wr_entry           (wr_entry),
        .link_state         (link_state),
        .disconnected       (disconnected)
    );

    sb_symbol_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .sb_clk   (sb_clk),
        .rst      (rst),
        .push     (push),
        .wr_entry (wr_entry),
        .pop      (pop),
        .rd_entry (rd_entry),
        .full     (full),
        .empty    (empty)
    );

    sb_symbol_timer u_timer (
        .sb_clk      (sb_clk),
        .rst         (rst),
        .rd_entry    (rd_entry),
        .empty       (empty),
        .link_state  (link_state),
        .pop         (pop),
        .trans       (trans),
        .crc_en      (crc_en),
        .sbtx_sel    (sbtx_sel),
        .trans_sent  (trans_sent),
        .trans_state (trans_state)
    );

endmodule

//--- verilog/sb_symbol_timer.sv
`timescale 1ns/1ps

module sb_symbol_timer (
    input  logic                sb_clk,
    input  logic                rst,
    input  sb_pkg::sym_entry_t  rd_entry,             // FIFO head on the line
    input  logic                empty,
    input  sb_pkg::link_state_e link_state,
    output logic                pop,
    output logic [9:0]          trans,
    output logic                crc_en,
    output logic                sbtx_sel,
    output logic                trans_sent,
    output sb_pkg::link_state_e trans_state
);

    localparam int CNT_W = $clog2(sb_pkg::SYMBOL_HOLD);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(sb_pkg::SYMBOL_HOLD - 1);

    logic             busy_q;                         // Head entry is being sent
    logic [CNT_W-1:0] cnt_q;                          // Hold cycle index
    logic             hold_done;

    assign hold_done = busy_q && !empty && (cnt_q == LAST_CNT);
    assign pop       = hold_done;                     // Release at end of hold

    // Line outputs, idle level from the registered link state
    always_comb begin
        if (busy_q) begin
            trans = rd_entry.symbol;
        end else if (trans_state == sb_pkg::LINK_DISC) begin
            trans = sb_pkg::LINE_DISC;
        end else begin
            trans = sb_pkg::LINE_IDLE;
        end
    end

    assign crc_en   = busy_q && rd_entry.crc_en;
    assign sbtx_sel = busy_q && rd_entry.crc_sel;     // Outer CRC mux select

    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            busy_q      <= 1'b0;
            cnt_q       <= '0;
            trans_sent  <= 1'b0;
            trans_state <= sb_pkg::LINK_DISC;
        end else begin
            trans_state <= link_state;
            trans_sent  <= hold_done && rd_entry.last; // One cycle after last hold
            if (!busy_q) begin
                if (!empty) begin
                    busy_q <= 1'b1;                   // Load head entry
                    cnt_q  <= '0;
                end
            end else if (!empty) begin
                if (cnt_q == LAST_CNT) begin
                    cnt_q <= '0;
                    if (rd_entry.last) begin
                        busy_q <= 1'b0;               // Transaction done, go free
                    end
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    a_sent_pulse: assert property (@(posedge sb_clk) disable iff (!rst)
        trans_sent |=> !trans_sent)
        else $error("trans_sent high for more than one cycle");

endmodule

//--- verilog/sb_symbol_fifo.sv
`timescale 1ns/1ps

module sb_symbol_fifo #(
    parameter int DEPTH = 4
) (
    input  logic               sb_clk,
    input  logic               rst,
    input  logic               push,
    input  sb_pkg::sym_entry_t wr_entry,
    input  logic               pop,
    output sb_pkg::sym_entry_t rd_entry,              // Head entry
    output logic               full,
    output logic               empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    sb_pkg::sym_entry_t mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;                        // Occupancy

    assign rd_entry = mem[rd_ptr];
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);

    always_ff @(posedge sb_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;              // Both or neither
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge sb_clk) disable iff (!rst)
        full |-> !push)
        else $error("push into full symbol FIFO");

    a_no_underflow: assert property (@(posedge sb_clk) disable iff (!rst)
        empty |-> !pop)
        else $error("pop from empty symbol FIFO");

endmodule

//--- verilog/sb_txn_sequencer.sv
`timescale 1ns/1ps

module sb_txn_sequencer (
    input  logic                sb_clk,
    input  logic                rst,
    input  logic [23:0]         sb_read,              // Read data, low byte first
    input  sb_pkg::txn_sel_e    trans_sel,
    input  logic                disconnect_sbtx,
    input  logic                tdisconnect_tx_min,
    input  logic                full,                 // FIFO back-pressure
    output logic                push,
    output sb_pkg::sym_entry_t  wr_entry,
    output sb_pkg::link_state_e link_state,
    output logic                disconnected
);

    sb_pkg::seq_state_e state_q;                      // Current symbol slot
    sb_pkg::seq_state_e state_d;
    sb_pkg::seq_state_e sym_next;                     // Slot after a push
    sb_pkg::txn_sel_e   sel_q;                        // Latched request
    logic [23:0]        read_q;                       // Latched response data
    logic [1:0]         byte_idx_q;                   // Data byte in flight
    logic [7:0]         data_byte;
    logic               req_ok;
    logic               take;                         // Request accepted
    logic               in_txn;

    assign req_ok = trans_sel inside {sb_pkg::TXN_READ_CMD, sb_pkg::TXN_READ_RSP,
                                      sb_pkg::TXN_TRAIN};
    assign take   = (state_q == sb_pkg::ST_IDLE) && !disconnect_sbtx && req_ok;
    assign in_txn = (state_q != sb_pkg::ST_DISC) && (state_q != sb_pkg::ST_IDLE);
    assign push   = in_txn && !full;                  // One entry per free cycle

    always_comb begin
        case (byte_idx_q)
            2'd0:    data_byte = read_q[7:0];         // Low byte goes first
            2'd1:    data_byte = read_q[15:8];
            default: data_byte = read_q[23:16];
        endcase
    end

    // Entry for the current slot and the slot that follows it
    always_comb begin
        wr_entry = '0;
        sym_next = state_q;
        case (state_q)
            sb_pkg::ST_DLE1: begin
                wr_entry.symbol = sb_pkg::frame_byte(sb_pkg::DLE_SYM);
                sym_next = (sel_q == sb_pkg::TXN_TRAIN) ? sb_pkg::ST_LSE : sb_pkg::ST_STX;
            end
            sb_pkg::ST_STX: begin
                wr_entry.symbol = sb_pkg::frame_byte((sel_q == sb_pkg::TXN_READ_CMD) ?
                                                     sb_pkg::STX_CMD_SYM :
                                                     sb_pkg::STX_RSP_SYM);
                wr_entry.crc_en = 1'b1;               // CRC starts at STX
                sym_next = sb_pkg::ST_ADDR;
            end
            sb_pkg::ST_ADDR: begin
                wr_entry.symbol = sb_pkg::frame_byte(sb_pkg::READ_ADDR);
                wr_entry.crc_en = 1'b1;
                sym_next = sb_pkg::ST_LEN;
            end
            sb_pkg::ST_LEN: begin
                wr_entry.symbol = sb_pkg::frame_byte(sb_pkg::READ_LEN);
                wr_entry.crc_en = 1'b1;
                sym_next = (sel_q == sb_pkg::TXN_READ_RSP) ? sb_pkg::ST_DATA :
                                                             sb_pkg::ST_CRC_LO;
            end
            sb_pkg::ST_DATA: begin
                wr_entry.symbol = sb_pkg::frame_byte(data_byte);
                wr_entry.crc_en = 1'b1;
                if (byte_idx_q == 2'd2) begin         // Third byte done
                    sym_next = sb_pkg::ST_CRC_LO;
                end
            end
            sb_pkg::ST_CRC_LO: begin
                wr_entry.crc_sel = 1'b1;              // Outer mux inserts CRC
                sym_next = sb_pkg::ST_CRC_HI;
            end
            sb_pkg::ST_CRC_HI: begin
                wr_entry.crc_sel = 1'b1;
                sym_next = sb_pkg::ST_DLE2;
            end
            sb_pkg::ST_DLE2: begin
                wr_entry.symbol = sb_pkg::frame_byte(sb_pkg::DLE_SYM);
                sym_next = sb_pkg::ST_ETX;
            end
            sb_pkg::ST_ETX: begin
                wr_entry.symbol = sb_pkg::frame_byte(sb_pkg::ETX_SYM);
                wr_entry.last = 1'b1;
                sym_next = sb_pkg::ST_IDLE;
            end
            sb_pkg::ST_LSE: begin
                wr_entry.symbol = sb_pkg::frame_byte(sb_pkg::LSE_SYM);
                sym_next = sb_pkg::ST_CLSE;
            end
            sb_pkg::ST_CLSE: begin
                wr_entry.symbol = sb_pkg::frame_byte(sb_pkg::CLSE_SYM);
                wr_entry.last = 1'b1;                 // Training ends here
                sym_next = sb_pkg::ST_IDLE;
            end
            default: begin
                sym_next = state_q;                   // DISC and IDLE push nothing
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            sb_pkg::ST_DISC: begin
                if (!disconnect_sbtx && tdisconnect_tx_min) begin
                    state_d = sb_pkg::ST_IDLE;
                end
            end
            sb_pkg::ST_IDLE: begin
                if (disconnect_sbtx) begin
                    state_d = sb_pkg::ST_DISC;
                end else if (take) begin
                    state_d = sb_pkg::ST_DLE1;
                end
            end
            default: begin
                if (push) begin
                    state_d = sym_next;               // Full stalls the slot
                end
            end
        endcase
    end

    always_comb begin
        case (state_q)
            sb_pkg::ST_DISC: link_state = sb_pkg::LINK_DISC;
            sb_pkg::ST_IDLE: link_state = sb_pkg::LINK_IDLE;
            default:         link_state = sb_pkg::LINK_BUSY;
        endcase
    end

    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            state_q      <= sb_pkg::ST_DISC;
            sel_q        <= sb_pkg::TXN_NONE;
            byte_idx_q   <= 2'd0;
            disconnected <= 1'b1;
        end else begin
            state_q      <= state_d;
            disconnected <= (state_q == sb_pkg::ST_DISC); // Lags state by a cycle
            if (take) begin
                sel_q      <= trans_sel;
                byte_idx_q <= 2'd0;
            end else if (push && state_q == sb_pkg::ST_DATA) begin
                byte_idx_q <= byte_idx_q + 2'd1;
            end
        end
    end

    always_ff @(posedge sb_clk) begin
        if (take) begin
            read_q <= sb_read;                        // Sampled with the request
        end
    end

    a_sel_legal: assert property (@(posedge sb_clk) disable iff (!rst)
        in_txn |-> sel_q inside {sb_pkg::TXN_READ_CMD, sb_pkg::TXN_READ_RSP,
                                 sb_pkg::TXN_TRAIN})
        else $error("sequencer running with illegal latched code %0d", sel_q);

endmodule

//--- verilog/sb_pkg.sv
package sb_pkg;

    // Line symbol geometry
    localparam int SYMBOL_BITS = 10;                  // Start, payload byte, stop
    localparam int SYMBOL_HOLD = 10;                  // sb_clk cycles per symbol

    // Payload codes
    localparam logic [7:0] DLE_SYM     = 8'hFE;
    localparam logic [7:0] STX_CMD_SYM = 8'h05;       // Command frame
    localparam logic [7:0] STX_RSP_SYM = 8'h04;       // Response frame
    localparam logic [7:0] LSE_SYM     = 8'h80;
    localparam logic [7:0] CLSE_SYM    = 8'h7F;       // Complement of LSE
    localparam logic [7:0] ETX_SYM     = 8'h40;

    // Fixed fields of a read
    localparam logic [7:0] READ_ADDR = 8'h4E;
    localparam logic [7:0] READ_LEN  = 8'h03;         // Three data bytes

    // Line levels outside a transaction
    localparam logic [SYMBOL_BITS-1:0] LINE_IDLE = {SYMBOL_BITS{1'b1}};
    localparam logic [SYMBOL_BITS-1:0] LINE_DISC = {SYMBOL_BITS{1'b0}};

    typedef enum logic [2:0] {
        TXN_NONE     = 3'd0,
        TXN_READ_CMD = 3'd2,
        TXN_READ_RSP = 3'd3,
        TXN_TRAIN    = 3'd4
    } txn_sel_e;

    typedef enum logic [1:0] {
        LINK_DISC = 2'd0,
        LINK_IDLE = 2'd1,
        LINK_BUSY = 2'd2
    } link_state_e;

    // Sequencer states, one per symbol slot
    typedef enum logic [3:0] {
        ST_DISC   = 4'd0,
        ST_IDLE   = 4'd1,
        ST_DLE1   = 4'd2,
        ST_STX    = 4'd3,
        ST_ADDR   = 4'd4,
        ST_LEN    = 4'd5,
        ST_DATA   = 4'd6,
        ST_CRC_LO = 4'd7,
        ST_CRC_HI = 4'd8,
        ST_DLE2   = 4'd9,
        ST_ETX    = 4'd10,
        ST_LSE    = 4'd11,
        ST_CLSE   = 4'd12
    } seq_state_e;

    typedef struct packed {
        logic [SYMBOL_BITS-1:0] symbol;               // Framed line symbol
        logic                   crc_en;               // Symbol covered by CRC
        logic                   crc_sel;              // CRC byte slot
        logic                   last;                 // Final symbol of transaction
    } sym_entry_t;

    function automatic logic [SYMBOL_BITS-1:0] frame_byte(input logic [7:0] payload);
        return {1'b1, payload, 1'b0};                 // Start high, stop low
    endfunction

endpackage
